// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hyperbus_phy
FILELIST  ?= hyperbus_phy.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hyperbus_cmd_addr.sv ====
`default_nettype none

module hyperbus_cmd_addr
    import hyperbus_pkg::*;
(
    input  logic [31:0]        local_address_i,
    input  logic               local_write_i,
    hyperbus_ctrl_if.ca        ctrl,
    output logic [15:0]        ca_word_o
);

    cmd_addr_t cmd_addr;

    always_comb begin
        cmd_addr                   = '0;
        cmd_addr.fields.rw         = ~local_write_i;
        cmd_addr.fields.addr_space = 1'b0;  // memory space
        cmd_addr.fields.burst_type = 1'b1;  // linear burst
        cmd_addr.fields.addr_upper = local_address_i[31:3];
        cmd_addr.fields.addr_lower = local_address_i[2:0];  // column within the row
    end

    always_comb begin
        case (ctrl.ca_sel)
            2'd0:    ca_word_o = cmd_addr.words[0];
            2'd1:    ca_word_o = cmd_addr.words[1];
            2'd2:    ca_word_o = cmd_addr.words[2];
            default: ca_word_o = 16'h0000;
        endcase
    end

    // the fsm only ever steps through words 0..2
    always_comb begin
        assert final (ctrl.ca_sel != 2'd3)
            else $error("ca_sel selects a word past the command/address");
    end

endmodule

`default_nettype wire

// ==== hyperbus_ctrl_if.sv ====
`default_nettype none

// controls from the transaction FSM to the data path
interface hyperbus_ctrl_if;

    logic [1:0] ca_sel;      // which CA word to send
    logic       en_write;    // data mux: tx data instead of CA
    logic       en_capture;  // read window open
    logic       dq_oe;
    logic       rwds_oe;

    modport fsm (
        output ca_sel,
        output en_write,
        output en_capture,
        output dq_oe,
        output rwds_oe
    );

    modport ddr (
        input en_write,
        input en_capture,
        input dq_oe,
        input rwds_oe
    );

    modport ca (
        input ca_sel
    );

endinterface

`default_nettype wire

// ==== hyperbus_ddr_io.sv ====
`default_nettype none

module hyperbus_ddr_io (
    input  logic         clk0,
    input  logic         rst_ni,
    hyperbus_ctrl_if.ddr ctrl,
    input  logic [15:0]  ca_word_i,
    input  logic [15:0]  tx_data_i,
    input  logic [1:0]   tx_strb_i,
    input  logic         hyper_rwds_i,
    input  logic [7:0]   hyper_dq_hi_i,
    input  logic [7:0]   hyper_dq_lo_i,
    output logic [7:0]   hyper_dq_hi_o,
    output logic [7:0]   hyper_dq_lo_o,
    output logic [1:0]   hyper_rwds_o,
    output logic         hyper_dq_oe_o,
    output logic         hyper_rwds_oe_o,
    output logic [15:0]  rx_word_o,
    output logic         rx_strobe_o
);

    logic [15:0] dq_out_q;
    logic        capture;

    assign capture = ctrl.en_capture & hyper_rwds_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            hyper_dq_oe_o   <= 1'b0;
            hyper_rwds_oe_o <= 1'b0;
            hyper_rwds_o    <= 2'b00;
            rx_strobe_o     <= 1'b0;
        end else begin
            hyper_dq_oe_o   <= ctrl.dq_oe;
            hyper_rwds_oe_o <= ctrl.rwds_oe;
            hyper_rwds_o    <= ctrl.en_write ? tx_strb_i : 2'b00;  // mask, high = skip byte
            rx_strobe_o     <= capture;
        end
    end

    always_ff @(posedge clk0) begin
        dq_out_q <= ctrl.en_write ? tx_data_i : ca_word_i;
        if (capture) begin
            rx_word_o <= {hyper_dq_hi_i, hyper_dq_lo_i};  // rising edge byte is the high one
        end
    end

    assign hyper_dq_hi_o = dq_out_q[15:8];
    assign hyper_dq_lo_o = dq_out_q[7:0];

endmodule

`default_nettype wire

// ==== hyperbus_phy.f ====
hyperbus_pkg.sv
hyperbus_ctrl_if.sv
hyperbus_cmd_addr.sv
hyperbus_ddr_io.sv
hyperbus_rx_fifo.sv
hyperbus_trans_fsm.sv
hyperbus_phy.sv
tb_clk_gen.sv
hyperram_model.sv
tb_hyperbus_phy.sv

// ==== hyperbus_phy.sv ====
`default_nettype none

module hyperbus_phy
    import hyperbus_pkg::*;
(
    input  logic                   clk0,
    input  logic                   rst_ni,
    // transactions
    input  logic                   trans_valid_i,
    output logic                   trans_ready_o,
    input  logic [31:0]            trans_address_i,
    input  logic [NR_CS-1:0]       trans_cs_i,
    input  logic                   trans_write_i,
    input  logic [BURST_WIDTH-1:0] trans_burst_i,
    // write data
    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,
    input  logic [15:0]            tx_data_i,
    input  logic [1:0]             tx_strb_i,
    // read data
    output logic                   rx_valid_o,
    input  logic                   rx_ready_i,
    output logic [15:0]            rx_data_o,
    // device side
    output logic [NR_CS-1:0]       hyper_cs_no,
    output logic                   hyper_ck_en_o,
    output logic [1:0]             hyper_rwds_o,
    input  logic                   hyper_rwds_i,
    output logic                   hyper_rwds_oe_o,
    input  logic [7:0]             hyper_dq_hi_i,
    input  logic [7:0]             hyper_dq_lo_i,
    output logic [7:0]             hyper_dq_hi_o,
    output logic [7:0]             hyper_dq_lo_o,
    output logic                   hyper_dq_oe_o,
    output logic                   hyper_reset_no
);

    logic [31:0] local_address;
    logic        local_write;
    logic [15:0] ca_word;
    logic [15:0] rx_word;
    logic        rx_strobe;
    logic        rx_wait;

    hyperbus_ctrl_if i_ctrl_if ();

    assign hyper_reset_no = 1'b1;  // device never held in reset

    hyperbus_trans_fsm i_trans_fsm (
        .clk0            (clk0),
        .rst_ni          (rst_ni),
        .trans_valid_i   (trans_valid_i),
        .trans_address_i (trans_address_i),
        .trans_cs_i      (trans_cs_i),
        .trans_write_i   (trans_write_i),
        .trans_burst_i   (trans_burst_i),
        .tx_valid_i      (tx_valid_i),
        .rx_wait_i       (rx_wait),
        .trans_ready_o   (trans_ready_o),
        .tx_ready_o      (tx_ready_o),
        .local_address_o (local_address),
        .local_write_o   (local_write),
        .hyper_cs_no     (hyper_cs_no),
        .hyper_ck_en_o   (hyper_ck_en_o),
        .ctrl            (i_ctrl_if.fsm)
    );

    hyperbus_cmd_addr i_cmd_addr (
        .local_address_i (local_address),
        .local_write_i   (local_write),
        .ctrl            (i_ctrl_if.ca),
        .ca_word_o       (ca_word)
    );

    hyperbus_ddr_io i_ddr_io (
        .clk0            (clk0),
        .rst_ni          (rst_ni),
        .ctrl            (i_ctrl_if.ddr),
        .ca_word_i       (ca_word),
        .tx_data_i       (tx_data_i),
        .tx_strb_i       (tx_strb_i),
        .hyper_rwds_i    (hyper_rwds_i),
        .hyper_dq_hi_i   (hyper_dq_hi_i),
        .hyper_dq_lo_i   (hyper_dq_lo_i),
        .hyper_dq_hi_o   (hyper_dq_hi_o),
        .hyper_dq_lo_o   (hyper_dq_lo_o),
        .hyper_rwds_o    (hyper_rwds_o),
        .hyper_dq_oe_o   (hyper_dq_oe_o),
        .hyper_rwds_oe_o (hyper_rwds_oe_o),
        .rx_word_o       (rx_word),
        .rx_strobe_o     (rx_strobe)
    );

    hyperbus_rx_fifo i_rx_fifo (
        .clk0        (clk0),
        .rst_ni      (rst_ni),
        .rx_word_i   (rx_word),
        .rx_strobe_i (rx_strobe),
        .rx_ready_i  (rx_ready_i),
        .rx_data_o   (rx_data_o),
        .rx_valid_o  (rx_valid_o),
        .rx_wait_o   (rx_wait)
    );

endmodule

`default_nettype wire

// ==== hyperbus_pkg.sv ====
`default_nettype none

package hyperbus_pkg;

    localparam int unsigned BURST_WIDTH   = 12;
    localparam int unsigned NR_CS         = 2;
    localparam int unsigned WAIT_CYCLES   = 6;  // initial latency, clk0 cycles
    localparam int unsigned RX_FIFO_DEPTH = 8;
    localparam int unsigned RX_WAIT_LEVEL = 5;  // fill that pauses the device clock

    localparam int unsigned WAIT_CNT_W = $clog2(WAIT_CYCLES + 1);
    localparam int unsigned RX_PTR_W   = $clog2(RX_FIFO_DEPTH);
    localparam int unsigned RX_CNT_W   = $clog2(RX_FIFO_DEPTH + 1);

    // 48-bit command/address, built as fields and sent as words
    typedef union packed {
        struct packed {
            logic        rw;           // 1 = read
            logic        addr_space;   // 0 = memory
            logic        burst_type;   // 1 = linear
            logic [28:0] addr_upper;
            logic [12:0] reserved;
            logic [2:0]  addr_lower;
        } fields;
        logic [0:2][15:0] words;       // word 0 goes out first
    } cmd_addr_t;

    typedef enum logic [3:0] {
        STANDBY,
        CMD_ADDR,
        WAIT2,
        WAIT,
        DATA_W,
        DATA_R,
        WAIT_R,
        END
    } hyper_trans_t;

endpackage

`default_nettype wire

// ==== hyperbus_rx_fifo.sv ====
`default_nettype none

module hyperbus_rx_fifo
    import hyperbus_pkg::*;
(
    input  logic        clk0,
    input  logic        rst_ni,
    input  logic [15:0] rx_word_i,
    input  logic        rx_strobe_i,
    input  logic        rx_ready_i,
    output logic [15:0] rx_data_o,
    output logic        rx_valid_o,
    output logic        rx_wait_o
);

    logic [15:0]         mem [RX_FIFO_DEPTH];
    logic [RX_PTR_W-1:0] wr_ptr_q;
    logic [RX_PTR_W-1:0] rd_ptr_q;
    logic [RX_CNT_W-1:0] fill_q;
    logic                pop;

    assign pop        = rx_valid_o & rx_ready_i;
    assign rx_valid_o = (fill_q != '0);
    assign rx_data_o  = mem[rd_ptr_q];
    assign rx_wait_o  = (fill_q >= RX_CNT_W'(RX_WAIT_LEVEL));  // asks the fsm to stop the clock

    function automatic logic [RX_PTR_W-1:0] ptr_inc(input logic [RX_PTR_W-1:0] ptr);
        ptr_inc = (ptr == RX_PTR_W'(RX_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (rx_strobe_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({rx_strobe_i, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    always_ff @(posedge clk0) begin
        if (rx_strobe_i) begin
            mem[wr_ptr_q] <= rx_word_i;
        end
    end

    // the wait request must stop the device before the buffer overflows
    assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_strobe_i |-> (fill_q < RX_CNT_W'(RX_FIFO_DEPTH)))
        else $error("rx fifo written while full");

endmodule

`default_nettype wire

// ==== hyperbus_testdata.txt ====
// kind (0 read, 1 write)  cs  address  burst  data seed  hold
// hold is the number of cycles rx_ready_i stays low after acceptance, all values hex
0 1 00000000 4 0 0
0 2 00000105 3 0 0
1 1 00000040 8 11 0
0 1 00000040 8 0 0
1 2 0000020b 5 2f 0
0 2 00000209 9 0 0
0 1 00000080 10 0 28
0 1 00000038 0c 0 3
1 1 000003fe 2 7 0
0 1 000003fc 4 0 0

// ==== hyperbus_trans_fsm.sv ====
`default_nettype none

module hyperbus_trans_fsm
    import hyperbus_pkg::*;
(
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  logic                   trans_valid_i,
    input  logic [31:0]            trans_address_i,
    input  logic [NR_CS-1:0]       trans_cs_i,
    input  logic                   trans_write_i,
    input  logic [BURST_WIDTH-1:0] trans_burst_i,
    input  logic                   tx_valid_i,
    input  logic                   rx_wait_i,
    output logic                   trans_ready_o,
    output logic                   tx_ready_o,
    output logic [31:0]            local_address_o,
    output logic                   local_write_o,
    output logic [NR_CS-1:0]       hyper_cs_no,
    output logic                   hyper_ck_en_o,
    hyperbus_ctrl_if.fsm           ctrl
);

    hyper_trans_t state_q, state_d;

    logic [WAIT_CNT_W-1:0]  wait_cnt_q;
    logic [BURST_WIDTH-1:0] burst_cnt_q;
    logic [1:0]             ca_cnt_q;

    // local copy of the transaction
    logic [31:0]            local_address_q;
    logic [NR_CS-1:0]       local_cs_q;
    logic                   local_write_q;
    logic [BURST_WIDTH-1:0] local_burst_q;

    logic             standby;
    logic [NR_CS-1:0] cs_sel;
    logic             clk_run_d;  // device clock runs next cycle
    logic             selected_d;
    logic             write_d;

    assign standby = (state_q == STANDBY);

    // in standby the incoming transaction bypasses the copy
    assign local_address_o = standby ? trans_address_i : local_address_q;
    assign local_write_o   = standby ? trans_write_i : local_write_q;
    assign cs_sel          = standby ? trans_cs_i : local_cs_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            STANDBY:  if (trans_valid_i && trans_ready_o) state_d = CMD_ADDR;
            CMD_ADDR: if (ca_cnt_q == 2'd2) state_d = WAIT2;
            WAIT2:    if (wait_cnt_q == '0) state_d = WAIT;
            WAIT: begin
                if (wait_cnt_q == '0) begin
                    state_d = local_write_q ? DATA_W : DATA_R;
                end
            end
            DATA_W:   if (burst_cnt_q == '0) state_d = END;
            DATA_R: begin
                if (burst_cnt_q == '0) begin
                    state_d = END;  // last word already taken, no pause needed
                end else if (rx_wait_i) begin
                    state_d = WAIT_R;
                end
            end
            WAIT_R:   if (!rx_wait_i) state_d = DATA_R;
            END:      if (wait_cnt_q == '0) state_d = STANDBY;
            default:  state_d = STANDBY;
        endcase
    end

    assign clk_run_d  = state_d inside {CMD_ADDR, WAIT2, WAIT, DATA_W, DATA_R};
    assign selected_d = clk_run_d || (state_d == WAIT_R);
    assign write_d    = (state_d == DATA_W);

    // controls lead the output registers by one cycle
    assign ctrl.ca_sel     = (state_q == CMD_ADDR && state_d == CMD_ADDR) ? ca_cnt_q + 2'd1 : 2'd0;
    assign ctrl.en_write   = write_d;
    assign ctrl.rwds_oe    = write_d;
    assign ctrl.dq_oe      = write_d || (state_d == CMD_ADDR);
    assign ctrl.en_capture = (state_q == DATA_R);
    assign tx_ready_o      = write_d;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= STANDBY;
            wait_cnt_q    <= '0;
            burst_cnt_q   <= '0;
            ca_cnt_q      <= '0;
            trans_ready_o <= 1'b0;
            hyper_ck_en_o <= 1'b0;
            hyper_cs_no   <= {NR_CS{1'b1}};
        end else begin
            state_q       <= state_d;
            trans_ready_o <= (state_d == STANDBY);
            hyper_ck_en_o <= clk_run_d;
            hyper_cs_no   <= ~(cs_sel & {NR_CS{selected_d}});
            case (state_q)
                STANDBY: ca_cnt_q <= '0;
                CMD_ADDR: begin
                    ca_cnt_q   <= ca_cnt_q + 2'd1;
                    wait_cnt_q <= WAIT_CNT_W'(WAIT_CYCLES - 1);
                end
                WAIT2: begin
                    if (wait_cnt_q == '0) begin
                        wait_cnt_q <= WAIT_CNT_W'(WAIT_CYCLES - 1);  // second latency half
                    end else begin
                        wait_cnt_q <= wait_cnt_q - 1'b1;
                    end
                end
                WAIT: begin
                    wait_cnt_q  <= wait_cnt_q - 1'b1;
                    burst_cnt_q <= local_burst_q - 1'b1;
                end
                DATA_W, DATA_R: begin
                    burst_cnt_q <= burst_cnt_q - 1'b1;
                    wait_cnt_q  <= WAIT_CNT_W'(WAIT_CYCLES - 1);  // guard time
                end
                END: wait_cnt_q <= wait_cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk0) begin
        if (standby) begin
            local_address_q <= trans_address_i;
            local_cs_q      <= trans_cs_i;
            local_write_q   <= trans_write_i;
            local_burst_q   <= trans_burst_i;
        end
    end

    // write data has no stall path
    assert property (@(posedge clk0) disable iff (!rst_ni) tx_ready_o |-> tx_valid_i)
        else $error("tx data missing during write burst");

    assert property (@(posedge clk0) disable iff (!rst_ni)
        state_q inside {STANDBY, CMD_ADDR, WAIT2, WAIT, DATA_W, DATA_R, WAIT_R, END})
        else $error("illegal transaction state");

    assert property (@(posedge clk0) disable iff (!rst_ni) $onehot0(~hyper_cs_no))
        else $error("more than one chip selected");

endmodule

`default_nettype wire

// ==== hyperram_model.sv ====
`default_nettype none

// behavioural HyperRAM, one clk0 cycle carries one word
module hyperram_model
    import hyperbus_pkg::*;
(
    input  logic             clk_i,
    input  logic [NR_CS-1:0] cs_ni,
    input  logic             ck_en_i,
    input  logic [7:0]       dq_hi_i,
    input  logic [7:0]       dq_lo_i,
    input  logic             dq_oe_i,
    input  logic [1:0]       rwds_i,
    input  logic             rwds_oe_i,
    output logic [7:0]       dq_hi_o,
    output logic [7:0]       dq_lo_o,
    output logic             rwds_o
);

    localparam int unsigned MEM_WORDS   = 1024;
    localparam int unsigned DATA_START  = 3 + 2 * WAIT_CYCLES;  // CA words, then fixed latency
    localparam int unsigned DRIVE_DELAY = 10;

    logic [15:0] mem [MEM_WORDS];
    logic [47:0] ca;
    logic [31:0] addr;
    int unsigned cnt;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 16'(i) ^ 16'hA5A5;
        end
        cnt     = 0;
        ca      = '0;
        addr    = '0;
        rwds_o  = 1'b0;
        dq_hi_o = 8'h00;
        dq_lo_o = 8'h00;
    end

    // acts a little after each rising edge, when the controller outputs have settled
    always @(posedge clk_i) begin
        #DRIVE_DELAY;
        rwds_o = 1'b0;
        if (&cs_ni) begin
            cnt = 0;  // next selection starts with CA
        end else if (ck_en_i) begin
            if (cnt < 3) begin
                ca = {ca[31:0], dq_hi_i, dq_lo_i};  // word 0 ends up on top
            end else if (cnt >= DATA_START) begin
                addr = {ca[44:16], ca[2:0]} + 32'(cnt - DATA_START);  // linear burst
                if (ca[47]) begin
                    {dq_hi_o, dq_lo_o} = mem[addr[9:0]];
                    rwds_o = 1'b1;
                end else if (dq_oe_i && rwds_oe_i) begin
                    if (!rwds_i[1]) begin
                        mem[addr[9:0]][15:8] = dq_hi_i;
                    end
                    if (!rwds_i[0]) begin
                        mem[addr[9:0]][7:0] = dq_lo_i;
                    end
                end
            end
            cnt++;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD  = 50,
    parameter int unsigned RESET_CYCLES = 16,
    parameter int unsigned STIM_DELAY   = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #STIM_DELAY;
        rst_no = 1'b1;  // released like any other input
    end

endmodule

`default_nettype wire

// ==== tb_hyperbus_phy.sv ====
`default_nettype none

module tb_hyperbus_phy
    import hyperbus_pkg::*;
();

    localparam int unsigned STIM_DELAY = 10;
    localparam int unsigned TD_FIELDS  = 6;  // kind, cs, address, burst, data seed, hold
    localparam int unsigned TD_MAX     = 32;
    localparam int unsigned MEM_WORDS  = 1024;
    localparam int unsigned PAUSE_HOLD = 2 * WAIT_CYCLES + RX_WAIT_LEVEL + 8;

    logic                   clk0;
    logic                   rst_ni;
    logic                   trans_valid_i;
    logic                   trans_ready_o;
    logic [31:0]            trans_address_i;
    logic [NR_CS-1:0]       trans_cs_i;
    logic                   trans_write_i;
    logic [BURST_WIDTH-1:0] trans_burst_i;
    logic                   tx_valid_i;
    logic                   tx_ready_o;
    logic [15:0]            tx_data_i;
    logic [1:0]             tx_strb_i;
    logic                   rx_valid_o;
    logic                   rx_ready_i;
    logic [15:0]            rx_data_o;
    logic [NR_CS-1:0]       hyper_cs_no;
    logic                   hyper_ck_en_o;
    logic [1:0]             hyper_rwds_o;
    logic                   hyper_rwds_i;
    logic                   hyper_rwds_oe_o;
    logic [7:0]             hyper_dq_hi_i;
    logic [7:0]             hyper_dq_lo_i;
    logic [7:0]             hyper_dq_hi_o;
    logic [7:0]             hyper_dq_lo_o;
    logic                   hyper_dq_oe_o;
    logic                   hyper_reset_no;

    logic [31:0] testdata [TD_FIELDS * TD_MAX];
    logic [15:0] shadow [MEM_WORDS];  // expected memory contents
    logic [15:0] rx_q [$];
    logic        pause_seen;
    int          seed;
    int unsigned n_trans;
    int unsigned limit_cycles = 0;

    tb_clk_gen i_clk_gen (
        .clk_o  (clk0),
        .rst_no (rst_ni)
    );

    hyperbus_phy i_dut (.*);

    hyperram_model i_ram (
        .clk_i     (clk0),
        .cs_ni     (hyper_cs_no),
        .ck_en_i   (hyper_ck_en_o),
        .dq_hi_i   (hyper_dq_hi_o),
        .dq_lo_i   (hyper_dq_lo_o),
        .dq_oe_i   (hyper_dq_oe_o),
        .rwds_i    (hyper_rwds_o),
        .rwds_oe_i (hyper_rwds_oe_o),
        .dq_hi_o   (hyper_dq_hi_i),
        .dq_lo_o   (hyper_dq_lo_i),
        .rwds_o    (hyper_rwds_i)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ca(input cmd_addr_t got, input cmd_addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: command/address got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cs(input logic [NR_CS-1:0] got, input logic [NR_CS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: chip selects got %b expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // split rule: upper field is address 31..3, column is 2..0
    function automatic cmd_addr_t expected_ca(input logic [31:0] addr, input logic write);
        cmd_addr_t ca;
        ca                   = '0;
        ca.fields.rw         = !write;
        ca.fields.addr_space = 1'b0;
        ca.fields.burst_type = 1'b1;
        ca.fields.addr_upper = addr[31:3];
        ca.fields.addr_lower = addr[2:0];
        return ca;
    endfunction

    always @(negedge clk0) begin
        if (rx_valid_o && rx_ready_i) begin
            rx_q.push_back(rx_data_o);  // popped at the coming edge
        end
        if (!(&hyper_cs_no) && !hyper_ck_en_o) begin
            pause_seen = 1'b1;
        end
    end

    task automatic run_trans(input int unsigned idx);
        logic [31:0]      kind;
        logic [NR_CS-1:0] cs;
        logic [31:0]      addr;
        int unsigned      burst;
        int unsigned      hold;
        int unsigned      sent;
        int unsigned      guard;
        int               rnd;
        logic [9:0]       a;
        logic [15:0]      wdata [$];
        logic [1:0]       wstrb [$];
        cmd_addr_t        exp_ca;
        cmd_addr_t        got_ca;

        kind   = testdata[idx * TD_FIELDS];
        cs     = testdata[idx * TD_FIELDS + 1][NR_CS-1:0];
        addr   = testdata[idx * TD_FIELDS + 2];
        burst  = testdata[idx * TD_FIELDS + 3];
        hold   = testdata[idx * TD_FIELDS + 5];
        exp_ca = expected_ca(addr, kind[0]);
        if (kind[0]) begin
            seed = seed ^ int'(testdata[idx * TD_FIELDS + 4]);
            for (int i = 0; i < int'(burst); i++) begin
                rnd = $random(seed);
                wdata.push_back(rnd[15:0]);
                wstrb.push_back(rnd[17:16]);  // mixed masks
            end
        end
        rx_q.delete();
        pause_seen = 1'b0;

        @(posedge clk0);
        #STIM_DELAY;
        trans_valid_i   = 1'b1;
        trans_address_i = addr;
        trans_cs_i      = cs;
        trans_write_i   = kind[0];
        trans_burst_i   = BURST_WIDTH'(burst);
        rx_ready_i      = (hold == 0);
        if (kind[0]) begin
            tx_valid_i = 1'b1;
            tx_data_i  = wdata[0];
            tx_strb_i  = wstrb[0];
        end
        do @(negedge clk0); while (!trans_ready_o);
        @(posedge clk0);  // taken at this edge
        #STIM_DELAY;
        trans_valid_i = 1'b0;

        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    @(negedge clk0);
                    got_ca.words[i] = {hyper_dq_hi_o, hyper_dq_lo_o};
                    check_flag(hyper_dq_oe_o, 1'b1, "dq output enable during CA");
                    check_flag(hyper_ck_en_o, 1'b1, "clock enable during CA");
                    check_cs(hyper_cs_no, ~cs);
                end
                check_ca(got_ca, exp_ca);
            end
            begin
                sent = 0;
                while (kind[0] && sent < burst) begin
                    @(negedge clk0);
                    if (tx_ready_o) begin
                        sent++;
                        @(posedge clk0);
                        #STIM_DELAY;
                        // word taken at this edge is now on the bus
                        check_flag(hyper_rwds_oe_o, 1'b1, "rwds output enable during write");
                        check_flag(hyper_dq_oe_o, 1'b1, "dq output enable during write");
                        check_word({hyper_dq_hi_o, hyper_dq_lo_o}, wdata[sent - 1],
                                   "write data on dq");
                        check_word(16'(hyper_rwds_o), 16'(wstrb[sent - 1]), "write mask on rwds");
                        if (sent < burst) begin
                            tx_data_i = wdata[sent];
                            tx_strb_i = wstrb[sent];
                        end else begin
                            tx_valid_i = 1'b0;
                        end
                    end
                end
            end
            begin
                if (hold != 0) begin
                    repeat (hold) @(posedge clk0);
                    #STIM_DELAY;
                    rx_ready_i = 1'b1;
                end
            end
            begin
                guard = 0;
                @(negedge clk0);
                while (!(&hyper_cs_no)) @(negedge clk0);
                while (!trans_ready_o) begin
                    check_cs(hyper_cs_no, '1);
                    guard++;
                    @(negedge clk0);
                end
                check_count(int'(guard), WAIT_CYCLES, "guard cycles");
            end
        join

        if (kind[0]) begin
            check_flag(tx_ready_o, 1'b0, "tx_ready after the burst");
            for (int i = 0; i < int'(burst); i++) begin
                a = addr[9:0] + 10'(i);
                if (!wstrb[i][1]) begin
                    shadow[a][15:8] = wdata[i][15:8];  // rwds high masks the byte
                end
                if (!wstrb[i][0]) begin
                    shadow[a][7:0] = wdata[i][7:0];
                end
            end
        end else begin
            while (rx_q.size() < int'(burst)) @(posedge clk0);
            repeat (3) @(posedge clk0);  // room for a surplus word to show up
            check_count(rx_q.size(), int'(burst), "read words");
            for (int i = 0; i < int'(burst); i++) begin
                a = addr[9:0] + 10'(i);
                check_word(rx_q[i], shadow[a], "read data");
            end
            if (hold >= PAUSE_HOLD && burst > RX_WAIT_LEVEL + 2) begin
                check_flag(pause_seen, 1'b1, "clock paused under back-pressure");
            end
        end
    endtask

    initial begin
        int unsigned sum_burst;

        trans_valid_i   = 1'b0;
        trans_address_i = '0;
        trans_cs_i      = '0;
        trans_write_i   = 1'b0;
        trans_burst_i   = '0;
        tx_valid_i      = 1'b0;
        tx_data_i       = '0;
        tx_strb_i       = '0;
        rx_ready_i      = 1'b1;
        seed            = 79963;
        sum_burst       = 0;
        n_trans         = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 16'(i) ^ 16'hA5A5;
        end
        for (int i = 0; i < TD_FIELDS * TD_MAX; i++) begin
            testdata[i] = '1;  // end marker where the file stops
        end
        $readmemh("hyperbus_testdata.txt", testdata);
        while (n_trans < TD_MAX && testdata[n_trans * TD_FIELDS] != '1) begin
            sum_burst += testdata[n_trans * TD_FIELDS + 3];
            n_trans++;
        end
        if (n_trans == 0) begin
            $display("error: no transactions in hyperbus_testdata.txt");
            abort_run();
        end
        limit_cycles = 20 + n_trans * (sum_burst + 4 * WAIT_CYCLES + 40);

        wait (rst_ni === 1'b1);
        repeat (2) @(negedge clk0);
        check_cs(hyper_cs_no, '1);
        check_flag(hyper_ck_en_o, 1'b0, "clock enable after reset");
        check_flag(hyper_dq_oe_o, 1'b0, "dq output enable after reset");
        check_flag(hyper_rwds_oe_o, 1'b0, "rwds output enable after reset");
        check_flag(trans_ready_o, 1'b1, "trans_ready after reset");
        check_flag(tx_ready_o, 1'b0, "tx_ready after reset");
        check_flag(rx_valid_o, 1'b0, "rx_valid after reset");
        check_flag(hyper_reset_no, 1'b1, "device reset after reset");

        for (int unsigned t = 0; t < n_trans; t++) begin
            run_trans(t);
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk0);
        $display("error: run still busy after %0d cycles", limit_cycles);
        abort_run();
    end

endmodule

`default_nettype wire
